//--- cluster_periph_settings.svh
// Build-time settings of the cluster peripheral.
// Include this in any file that sizes ports or decodes register offsets.

`ifndef CLUSTER_PERIPH_SETTINGS_SVH
`define CLUSTER_PERIPH_SETTINGS_SVH

// Cluster shape.
`define CP_NR_CORES       4
`define CP_NUM_COUNTERS   4
`define CP_CNT_WIDTH      48

// Register port address width, data is always 32 bits.
`define CP_ADDR_WIDTH     12

// Selector i lives at CP_SEL_BASE + 8*i.
`define CP_SEL_BASE       12'h000

// Counter i low word at CP_CNT_BASE + 8*i, high bits 4 bytes above.
`define CP_CNT_BASE       12'h100

// One bit per counter.
`define CP_EN_ADDR        12'h200

// Wake-up set, clear and state (state is read only).
`define CP_CLINT_SET_ADDR 12'h300
`define CP_CLINT_CLR_ADDR 12'h308
`define CP_CLINT_ADDR     12'h310

// Instruction-cache prefetch enable in bit 0.
`define CP_PREFETCH_ADDR  12'h318

`endif

//--- cluster_periph_pkg.sv
// Types shared by the cluster peripheral blocks.
// Referenced with scoped names from the decoder, counter bank and wake-up block.

package cluster_periph_pkg;

  // Metric codes held in the selector registers.
  typedef enum logic [4:0] {
    Cycle           = 5'd0,
    TcdmAccessed    = 5'd1,
    TcdmCongested   = 5'd2,
    RetiredInstr    = 5'd3,
    RetiredLoad     = 5'd4,
    IcacheMiss      = 5'd5,
    IcacheHit       = 5'd6,
    DmaBusy         = 5'd7,
    DmaBytesWritten = 5'd8
  } perf_metric_e;

  // Field view of a selector word.
  typedef struct packed {
    logic [21:0]  reserved_hi;
    logic [1:0]   core;
    logic [2:0]   reserved_lo;
    perf_metric_e metric;
  } perf_sel_fields_t;

  // A selector word seen either as the raw bus word or as its fields.
  typedef union packed {
    logic [31:0]      raw;
    perf_sel_fields_t fields;
  } perf_sel_word_u;

  // What a register write is aimed at.
  typedef enum logic [2:0] {
    None     = 3'd0,
    Sel      = 3'd1,
    CntClear = 3'd2,
    Enable   = 3'd3,
    ClintSet = 3'd4,
    ClintClr = 3'd5,
    Prefetch = 3'd6
  } reg_target_e;

endpackage

//--- perf_counter_bank.sv
// Bank of selectable performance counters.
// Events are registered once, then each enabled counter adds its selected metric.
// Selectors, counters and the enable word are read back through rd_addr_i.

`timescale 1ns/1ps
`include "cluster_periph_settings.svh"

module perf_counter_bank (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  cluster_periph_pkg::reg_target_e      wr_target_i,
  input  logic [$clog2(`CP_NUM_COUNTERS)-1:0]  wr_index_i,
  input  logic [31:0]                          wr_data_i,
  input  logic [`CP_ADDR_WIDTH-1:0]            rd_addr_i,
  input  logic [`CP_NR_CORES-1:0]              retired_instr_i,
  input  logic [`CP_NR_CORES-1:0]              retired_load_i,
  input  logic [`CP_NR_CORES-1:0]              icache_miss_i,
  input  logic [`CP_NR_CORES-1:0]              icache_hit_i,
  input  logic                                 tcdm_accessed_i,
  input  logic                                 tcdm_congested_i,
  input  logic                                 dma_busy_i,
  input  logic [7:0]                           dma_bytes_written_i,
  output logic [31:0]                          rdata_o
);

  localparam int unsigned IdxW      = $clog2(`CP_NUM_COUNTERS);
  localparam int unsigned SpanBytes = 8 * `CP_NUM_COUNTERS;

  logic [`CP_NR_CORES-1:0] retired_instr_q;
  logic [`CP_NR_CORES-1:0] retired_load_q;
  logic [`CP_NR_CORES-1:0] icache_miss_q;
  logic [`CP_NR_CORES-1:0] icache_hit_q;
  logic                    tcdm_accessed_q;
  logic                    tcdm_congested_q;
  logic                    dma_busy_q;
  logic [7:0]              dma_bytes_written_q;

  cluster_periph_pkg::perf_metric_e   metric_q [`CP_NUM_COUNTERS];
  logic [$clog2(`CP_NR_CORES)-1:0]    core_q   [`CP_NUM_COUNTERS];
  logic [`CP_CNT_WIDTH-1:0]           cnt_q    [`CP_NUM_COUNTERS];
  logic [`CP_NUM_COUNTERS-1:0]        en_q;

  cluster_periph_pkg::perf_sel_word_u sel_wr;
  cluster_periph_pkg::perf_sel_word_u sel_rd;
  logic [`CP_ADDR_WIDTH-1:0]          sel_off;
  logic [`CP_ADDR_WIDTH-1:0]          cnt_off;

  // Metrics tracked right after reset, Cycle for any further counter.
  function automatic cluster_periph_pkg::perf_metric_e rst_metric(input int unsigned idx);
    case (idx)
      1:       return cluster_periph_pkg::RetiredInstr;
      2:       return cluster_periph_pkg::TcdmAccessed;
      3:       return cluster_periph_pkg::IcacheMiss;
      default: return cluster_periph_pkg::Cycle;
    endcase
  endfunction

  // One pipeline stage on all events to ease timing.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      retired_instr_q     <= '0;
      retired_load_q      <= '0;
      icache_miss_q       <= '0;
      icache_hit_q        <= '0;
      tcdm_accessed_q     <= 1'b0;
      tcdm_congested_q    <= 1'b0;
      dma_busy_q          <= 1'b0;
      dma_bytes_written_q <= '0;
    end else begin
      retired_instr_q     <= retired_instr_i;
      retired_load_q      <= retired_load_i;
      icache_miss_q       <= icache_miss_i;
      icache_hit_q        <= icache_hit_i;
      tcdm_accessed_q     <= tcdm_accessed_i;
      tcdm_congested_q    <= tcdm_congested_i;
      dma_busy_q          <= dma_busy_i;
      dma_bytes_written_q <= dma_bytes_written_i;
    end
  end

  assign sel_wr = cluster_periph_pkg::perf_sel_word_u'(wr_data_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      en_q <= '0;
    end else if (wr_target_i == cluster_periph_pkg::Enable) begin
      en_q <= wr_data_i[`CP_NUM_COUNTERS-1:0];
    end
  end

  for (genvar i = 0; i < `CP_NUM_COUNTERS; i++) begin : gen_cnt
    logic [`CP_CNT_WIDTH-1:0] inc;

    // Per-core metrics pick the bit of the selected core.
    always_comb begin
      case (metric_q[i])
        cluster_periph_pkg::Cycle:           inc = `CP_CNT_WIDTH'(1);
        cluster_periph_pkg::TcdmAccessed:    inc = `CP_CNT_WIDTH'(tcdm_accessed_q);
        cluster_periph_pkg::TcdmCongested:   inc = `CP_CNT_WIDTH'(tcdm_congested_q);
        cluster_periph_pkg::RetiredInstr:    inc = `CP_CNT_WIDTH'(retired_instr_q[core_q[i]]);
        cluster_periph_pkg::RetiredLoad:     inc = `CP_CNT_WIDTH'(retired_load_q[core_q[i]]);
        cluster_periph_pkg::IcacheMiss:      inc = `CP_CNT_WIDTH'(icache_miss_q[core_q[i]]);
        cluster_periph_pkg::IcacheHit:       inc = `CP_CNT_WIDTH'(icache_hit_q[core_q[i]]);
        cluster_periph_pkg::DmaBusy:         inc = `CP_CNT_WIDTH'(dma_busy_q);
        cluster_periph_pkg::DmaBytesWritten: inc = `CP_CNT_WIDTH'(dma_bytes_written_q);
        default:                             inc = '0;
      endcase
    end

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        metric_q[i] <= rst_metric(i);
        core_q[i]   <= '0;
      end else if (wr_target_i == cluster_periph_pkg::Sel && wr_index_i == IdxW'(i)) begin
        metric_q[i] <= sel_wr.fields.metric;
        core_q[i]   <= sel_wr.fields.core;
      end
    end

    // A clear wins over the increment.
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        cnt_q[i] <= '0;
      end else if (wr_target_i == cluster_periph_pkg::CntClear && wr_index_i == IdxW'(i)) begin
        cnt_q[i] <= '0;
      end else if (en_q[i]) begin
        cnt_q[i] <= cnt_q[i] + inc;
      end
    end

    // Software keeps selector codes within the defined metrics.
    assert property (@(posedge clk_i) disable iff (reset_i)
      (wr_target_i == cluster_periph_pkg::Sel && wr_index_i == IdxW'(i))
      |=> (metric_q[i] <= cluster_periph_pkg::DmaBytesWritten))
      else $error("counter %0d selects an undefined metric", i);
  end

  // Addresses below a base wrap to large offsets and fall out of range.
  assign sel_off = rd_addr_i - `CP_SEL_BASE;
  assign cnt_off = rd_addr_i - `CP_CNT_BASE;

  always_comb begin
    sel_rd  = '0;
    rdata_o = '0;
    if (sel_off < SpanBytes && rd_addr_i[2:0] == 3'b000) begin
      sel_rd.fields.metric = metric_q[sel_off[IdxW+2:3]];
      sel_rd.fields.core   = core_q[sel_off[IdxW+2:3]];
      rdata_o              = sel_rd.raw;
    end else if (cnt_off < SpanBytes && rd_addr_i[1:0] == 2'b00) begin
      if (rd_addr_i[2]) begin
        rdata_o = 32'(cnt_q[cnt_off[IdxW+2:3]][`CP_CNT_WIDTH-1:32]);
      end else begin
        rdata_o = cnt_q[cnt_off[IdxW+2:3]][31:0];
      end
    end else if (rd_addr_i == `CP_EN_ADDR) begin
      rdata_o = 32'(en_q);
    end
  end

endmodule

//--- wakeup_ctrl_regs.sv
// Per-core wake-up bits and the instruction-cache prefetch enable.
// Wake-up bits are set and cleared through separate write registers.

`timescale 1ns/1ps
`include "cluster_periph_settings.svh"

module wakeup_ctrl_regs (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  cluster_periph_pkg::reg_target_e wr_target_i,
  input  logic [31:0]                     wr_data_i,
  input  logic [`CP_ADDR_WIDTH-1:0]       rd_addr_i,
  output logic [`CP_NR_CORES-1:0]         cl_wakeup_o,
  output logic                            icache_prefetch_enable_o,
  output logic [31:0]                     rdata_o
);

  logic [`CP_NR_CORES-1:0] wakeup_q;
  logic                    prefetch_q;

  // Set ORs bits in, clear removes them.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wakeup_q <= '0;
    end else if (wr_target_i == cluster_periph_pkg::ClintSet) begin
      wakeup_q <= wakeup_q | wr_data_i[`CP_NR_CORES-1:0];
    end else if (wr_target_i == cluster_periph_pkg::ClintClr) begin
      wakeup_q <= wakeup_q & ~wr_data_i[`CP_NR_CORES-1:0];
    end
  end

  // Prefetching is on out of reset.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prefetch_q <= 1'b1;
    end else if (wr_target_i == cluster_periph_pkg::Prefetch) begin
      prefetch_q <= wr_data_i[0];
    end
  end

  assign cl_wakeup_o              = wakeup_q;
  assign icache_prefetch_enable_o = prefetch_q;

  // Set and clear registers are write only.
  always_comb begin
    case (rd_addr_i)
      `CP_CLINT_ADDR:    rdata_o = 32'(wakeup_q);
      `CP_PREFETCH_ADDR: rdata_o = 32'(prefetch_q);
      default:           rdata_o = '0;
    endcase
  end

endmodule

//--- periph_reg_decoder.sv
// Register port front end of the cluster peripheral.
// Turns each write into one target strobe and registers the read response.
// Responses come one cycle after the request, writes answer with zero.

`timescale 1ns/1ps
`include "cluster_periph_settings.svh"

module periph_reg_decoder (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                req_valid_i,
  input  logic                                req_write_i,
  input  logic [`CP_ADDR_WIDTH-1:0]           req_addr_i,
  input  logic [31:0]                         req_wdata_i,
  input  logic [31:0]                         cnt_rdata_i,
  input  logic [31:0]                         ctrl_rdata_i,
  output cluster_periph_pkg::reg_target_e     wr_target_o,
  output logic [$clog2(`CP_NUM_COUNTERS)-1:0] wr_index_o,
  output logic [31:0]                         wr_data_o,
  output logic                                rsp_valid_o,
  output logic [31:0]                         rsp_rdata_o
);

  localparam int unsigned IdxW      = $clog2(`CP_NUM_COUNTERS);
  localparam int unsigned SpanBytes = 8 * `CP_NUM_COUNTERS;

  logic [`CP_ADDR_WIDTH-1:0] sel_off;
  logic [`CP_ADDR_WIDTH-1:0] cnt_off;
  logic [31:0]               rd_word;

  assign sel_off = req_addr_i - `CP_SEL_BASE;
  assign cnt_off = req_addr_i - `CP_CNT_BASE;

  // The wake-up state address is read only and decodes to no target.
  always_comb begin
    wr_target_o = cluster_periph_pkg::None;
    wr_index_o  = '0;
    if (req_valid_i && req_write_i) begin
      if (sel_off < SpanBytes && req_addr_i[2:0] == 3'b000) begin
        wr_target_o = cluster_periph_pkg::Sel;
        wr_index_o  = sel_off[IdxW+2:3];
      end else if (cnt_off < SpanBytes && req_addr_i[1:0] == 2'b00) begin
        // Either half of a counter clears the whole counter.
        wr_target_o = cluster_periph_pkg::CntClear;
        wr_index_o  = cnt_off[IdxW+2:3];
      end else begin
        case (req_addr_i)
          `CP_EN_ADDR:        wr_target_o = cluster_periph_pkg::Enable;
          `CP_CLINT_SET_ADDR: wr_target_o = cluster_periph_pkg::ClintSet;
          `CP_CLINT_CLR_ADDR: wr_target_o = cluster_periph_pkg::ClintClr;
          `CP_PREFETCH_ADDR:  wr_target_o = cluster_periph_pkg::Prefetch;
          default:            wr_target_o = cluster_periph_pkg::None;
        endcase
      end
    end
  end

  assign wr_data_o = req_wdata_i;

  // Counter bank owns everything up to the enable word.
  assign rd_word = (req_addr_i <= `CP_EN_ADDR) ? cnt_rdata_i : ctrl_rdata_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_rdata_o <= (req_valid_i && !req_write_i) ? rd_word : '0;
  end

  // Every request is answered exactly one cycle later, and nothing else is.
  assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_o == $past(req_valid_i))
    else $error("response does not follow its request by one cycle");

endmodule

//--- cluster_periph_top.sv
// Top level of the cluster peripheral.
// Connects the register decoder to the counter bank and the wake-up block.

`timescale 1ns/1ps
`include "cluster_periph_settings.svh"

module cluster_periph_top (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        req_valid_i,
  input  logic                        req_write_i,
  input  logic [`CP_ADDR_WIDTH-1:0]   req_addr_i,
  input  logic [31:0]                 req_wdata_i,
  output logic                        rsp_valid_o,
  output logic [31:0]                 rsp_rdata_o,
  input  logic [`CP_NR_CORES-1:0]     retired_instr_i,
  input  logic [`CP_NR_CORES-1:0]     retired_load_i,
  input  logic [`CP_NR_CORES-1:0]     icache_miss_i,
  input  logic [`CP_NR_CORES-1:0]     icache_hit_i,
  input  logic                        tcdm_accessed_i,
  input  logic                        tcdm_congested_i,
  input  logic                        dma_busy_i,
  input  logic [7:0]                  dma_bytes_written_i,
  output logic [`CP_NR_CORES-1:0]     cl_wakeup_o,
  output logic                        icache_prefetch_enable_o
);

  cluster_periph_pkg::reg_target_e     wr_target;
  logic [$clog2(`CP_NUM_COUNTERS)-1:0] wr_index;
  logic [31:0]                         wr_data;
  logic [31:0]                         cnt_rdata;
  logic [31:0]                         ctrl_rdata;

  periph_reg_decoder periph_reg_decoder_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_write_i  (req_write_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .cnt_rdata_i  (cnt_rdata),
    .ctrl_rdata_i (ctrl_rdata),
    .wr_target_o  (wr_target),
    .wr_index_o   (wr_index),
    .wr_data_o    (wr_data),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_rdata_o  (rsp_rdata_o)
  );

  perf_counter_bank perf_counter_bank_inst (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .wr_target_i         (wr_target),
    .wr_index_i          (wr_index),
    .wr_data_i           (wr_data),
    .rd_addr_i           (req_addr_i),
    .retired_instr_i     (retired_instr_i),
    .retired_load_i      (retired_load_i),
    .icache_miss_i       (icache_miss_i),
    .icache_hit_i        (icache_hit_i),
    .tcdm_accessed_i     (tcdm_accessed_i),
    .tcdm_congested_i    (tcdm_congested_i),
    .dma_busy_i          (dma_busy_i),
    .dma_bytes_written_i (dma_bytes_written_i),
    .rdata_o             (cnt_rdata)
  );

  wakeup_ctrl_regs wakeup_ctrl_regs_inst (
    .clk_i                    (clk_i),
    .reset_i                  (reset_i),
    .wr_target_i              (wr_target),
    .wr_data_i                (wr_data),
    .rd_addr_i                (req_addr_i),
    .cl_wakeup_o              (cl_wakeup_o),
    .icache_prefetch_enable_o (icache_prefetch_enable_o),
    .rdata_o                  (ctrl_rdata)
  );

endmodule

//--- tb_cluster_periph.sv
// Self-checking testbench for the cluster peripheral.
// Drives register accesses and random events, concurrent assertions compare with a register model.

`timescale 1ns/1ps
`include "cluster_periph_settings.svh"

module tb_cluster_periph;

  logic                      clk_i;
  logic                      reset_i;
  logic                      req_valid_i;
  logic                      req_write_i;
  logic [`CP_ADDR_WIDTH-1:0] req_addr_i;
  logic [31:0]               req_wdata_i;
  logic                      rsp_valid_o;
  logic [31:0]               rsp_rdata_o;
  logic [`CP_NR_CORES-1:0]   retired_instr_i;
  logic [`CP_NR_CORES-1:0]   retired_load_i;
  logic [`CP_NR_CORES-1:0]   icache_miss_i;
  logic [`CP_NR_CORES-1:0]   icache_hit_i;
  logic                      tcdm_accessed_i;
  logic                      tcdm_congested_i;
  logic                      dma_busy_i;
  logic [7:0]                dma_bytes_written_i;
  logic [`CP_NR_CORES-1:0]   cl_wakeup_o;
  logic                      icache_prefetch_enable_o;

  // Register model, the _d copies change with the request and the _m copies at the edge.
  logic [31:0]               lfsr_q;
  int unsigned               errors;
  logic [31:0]               exp_rdata;
  logic [31:0]               exp_q;
  logic                      vld_q;
  logic [`CP_NR_CORES-1:0]   wake_d;
  logic [`CP_NR_CORES-1:0]   wake_m;
  logic                      pf_d;
  logic                      pf_m;
  logic [31:0]               en_d;
  logic [31:0]               sel_m [`CP_NUM_COUNTERS];
  logic [`CP_CNT_WIDTH-1:0]  cnt_m [`CP_NUM_COUNTERS];

  cluster_periph_top cluster_periph_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    exp_q  <= exp_rdata;
    vld_q  <= req_valid_i;
    wake_m <= wake_d;
    pf_m   <= pf_d;
  end

  // A response comes exactly one cycle after each request and at no other time.
  assert property (@(posedge clk_i) disable iff (reset_i) rsp_valid_o == vld_q)
    else begin
      errors++;
      $display("Error rsp_valid_o: got %h, expected %h",
               $sampled(rsp_valid_o), $sampled(vld_q));
    end

  // The response carries the word expected for the request one cycle earlier.
  assert property (@(posedge clk_i) disable iff (reset_i) rsp_valid_o |-> rsp_rdata_o == exp_q)
    else begin
      errors++;
      $display("Error rsp_rdata_o: got %h, expected %h", $sampled(rsp_rdata_o), $sampled(exp_q));
    end

  assert property (@(posedge clk_i) disable iff (reset_i) cl_wakeup_o == wake_m)
    else begin
      errors++;
      $display("Error cl_wakeup_o: got %h, expected %h", $sampled(cl_wakeup_o), $sampled(wake_m));
    end

  assert property (@(posedge clk_i) disable iff (reset_i) icache_prefetch_enable_o == pf_m)
    else begin
      errors++;
      $display("Error icache_prefetch_enable_o: got %h, expected %h",
               $sampled(icache_prefetch_enable_o), $sampled(pf_m));
    end

  // Right-shift Galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v[b]   = lfsr_q[0];
    end
  endtask

  task automatic idle();
    @(negedge clk_i);
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    exp_rdata   = '0;
  endtask

  task automatic drive_req(input logic wr, input logic [`CP_ADDR_WIDTH-1:0] addr,
                           input logic [31:0] data, input logic [31:0] exp);
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_write_i = wr;
    req_addr_i  = addr;
    req_wdata_i = data;
    exp_rdata   = exp;
  endtask

  // Updates the model from the register map, unmapped and read-only addresses change nothing.
  task automatic write_reg(input logic [`CP_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    drive_req(1'b1, addr, data, 32'd0);
    case (addr)
      `CP_EN_ADDR:        en_d = 32'(data[`CP_NUM_COUNTERS-1:0]);
      `CP_CLINT_SET_ADDR: wake_d = wake_d | data[`CP_NR_CORES-1:0];
      `CP_CLINT_CLR_ADDR: wake_d = wake_d & ~data[`CP_NR_CORES-1:0];
      `CP_PREFETCH_ADDR:  pf_d = data[0];
      default:            ;
    endcase
    if (addr < `CP_SEL_BASE + 12'd32 && addr[2:0] == 3'b000) begin
      sel_m[addr[4:3]] = data & 32'h0000_031F;
    end
    if (addr >= `CP_CNT_BASE && addr < `CP_CNT_BASE + 12'd32 && addr[1:0] == 2'b00) begin
      cnt_m[addr[4:3]] = '0;
    end
  endtask

  task automatic read_reg(input logic [`CP_ADDR_WIDTH-1:0] addr, input logic [31:0] exp);
    logic seen;
    drive_req(1'b0, addr, 32'd0, exp);
    seen = 1'b0;
    for (int t = 0; t < 8 && !seen; t++) begin
      idle();
      seen = rsp_valid_o;
    end
    if (!seen) begin
      $display("Timeout while waiting for the response to a read of address %h", addr);
      $display("TB FAILED");
      $finish;
    end
  endtask

  task automatic check_state();
    for (int i = 0; i < `CP_NUM_COUNTERS; i++) begin
      read_reg(`CP_SEL_BASE + 12'(8 * i), sel_m[i]);
      read_reg(`CP_CNT_BASE + 12'(8 * i), cnt_m[i][31:0]);
      read_reg(`CP_CNT_BASE + 12'(8 * i + 4), 32'(cnt_m[i][`CP_CNT_WIDTH-1:32]));
    end
    read_reg(`CP_EN_ADDR, en_d);
    read_reg(`CP_CLINT_ADDR, 32'(wake_d));
    read_reg(`CP_PREFETCH_ADDR, 32'(pf_d));
  endtask

  task automatic stop_events();
    retired_instr_i     = '0;
    retired_load_i      = '0;
    icache_miss_i       = '0;
    icache_hit_i        = '0;
    tcdm_accessed_i     = 1'b0;
    tcdm_congested_i    = 1'b0;
    dma_busy_i          = 1'b0;
    dma_bytes_written_i = '0;
  endtask

  // Counters 0 to 3 watch RetiredInstr on c0, IcacheHit on c1, TcdmCongested and DMA bytes.
  task automatic pulse_events(input logic [1:0] c0, input logic [1:0] c1);
    logic [31:0] r;
    idle();
    take_bits(16, r);
    retired_instr_i     = r[3:0];
    retired_load_i      = r[7:4];
    icache_miss_i       = r[11:8];
    icache_hit_i        = r[15:12];
    take_bits(11, r);
    tcdm_accessed_i     = r[0];
    tcdm_congested_i    = r[1];
    dma_busy_i          = r[2];
    dma_bytes_written_i = r[10:3];
    cnt_m[0] = cnt_m[0] + retired_instr_i[c0];
    cnt_m[1] = cnt_m[1] + icache_hit_i[c1];
    cnt_m[2] = cnt_m[2] + tcdm_congested_i;
    cnt_m[3] = cnt_m[3] + dma_bytes_written_i;
  endtask

  initial begin
    logic [31:0] r;
    logic [1:0]  c0;
    logic [1:0]  c1;
    int          n;
    lfsr_q      = 32'd97425;
    errors      = 0;
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    exp_rdata   = '0;
    wake_d      = '0;
    wake_m      = '0;
    pf_d        = 1'b1;
    pf_m        = 1'b1;
    en_d        = '0;
    sel_m[0]    = 32'(cluster_periph_pkg::Cycle);
    sel_m[1]    = 32'(cluster_periph_pkg::RetiredInstr);
    sel_m[2]    = 32'(cluster_periph_pkg::TcdmAccessed);
    sel_m[3]    = 32'(cluster_periph_pkg::IcacheMiss);
    for (int i = 0; i < `CP_NUM_COUNTERS; i++) begin
      cnt_m[i] = '0;
    end
    stop_events();
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;

    check_state();

    // Counter 0 still selects Cycle and counts once per cycle between the two strobes.
    take_bits(5, r);
    n = int'(r[4:0]) + 2;
    write_reg(`CP_EN_ADDR, 32'h1);
    repeat (n) idle();
    write_reg(`CP_EN_ADDR, 32'h0);
    cnt_m[0] = `CP_CNT_WIDTH'(n + 1);
    check_state();

    take_bits(2, r);
    c0 = r[1:0];
    take_bits(2, r);
    c1 = r[1:0];
    write_reg(`CP_SEL_BASE, 32'(cluster_periph_pkg::RetiredInstr) | (32'(c0) << 8));
    write_reg(`CP_SEL_BASE + 12'd8, 32'(cluster_periph_pkg::IcacheHit) | (32'(c1) << 8));
    write_reg(`CP_SEL_BASE + 12'd16, 32'(cluster_periph_pkg::TcdmCongested));
    write_reg(`CP_SEL_BASE + 12'd24, 32'(cluster_periph_pkg::DmaBytesWritten));
    for (int i = 0; i < `CP_NUM_COUNTERS; i++) begin
      write_reg(`CP_CNT_BASE + 12'(8 * i), 32'd0);
    end
    write_reg(`CP_EN_ADDR, 32'hF);
    take_bits(5, r);
    repeat (int'(r[4:0]) + 8) pulse_events(c0, c1);
    idle();
    stop_events();
    repeat (3) idle();
    write_reg(`CP_EN_ADDR, 32'h0);
    check_state();

    // The high half clears the whole counter just like the low half.
    write_reg(`CP_CNT_BASE + 12'd12, 32'd0);
    write_reg(`CP_CNT_BASE + 12'd24, 32'd0);
    check_state();

    for (int k = 0; k < 24; k++) begin
      take_bits(5, r);
      if (r[4]) begin
        write_reg(`CP_CLINT_CLR_ADDR, 32'(r[3:0]));
      end else begin
        write_reg(`CP_CLINT_SET_ADDR, 32'(r[3:0]));
      end
      if (k % 6 == 5) begin
        take_bits(1, r);
        write_reg(`CP_PREFETCH_ADDR, r);
        read_reg(`CP_CLINT_ADDR, 32'(wake_d));
      end
    end
    check_state();

    read_reg(12'h004, 32'd0);
    read_reg(12'h102, 32'd0);
    read_reg(12'h120, 32'd0);
    read_reg(12'h204, 32'd0);
    read_reg(12'h31C, 32'd0);
    read_reg(12'h400, 32'd0);
    read_reg(12'hFFC, 32'd0);
    write_reg(12'h004, 32'hFFFF_FFFF);
    write_reg(12'h120, 32'hFFFF_FFFF);
    write_reg(12'h204, 32'hFFFF_FFFF);
    write_reg(`CP_CLINT_ADDR, 32'hFFFF_FFFF);
    write_reg(12'hFFC, 32'hFFFF_FFFF);
    check_state();

    idle();
    idle();
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+.
cluster_periph_pkg.sv
perf_counter_bank.sv
wakeup_ctrl_regs.sv
periph_reg_decoder.sv
cluster_periph_top.sv
tb_cluster_periph.sv
